//--- src/ecc_pkg.sv
package ecc_pkg;

    localparam int ECC_DATA_W  = 92;
    localparam int ECC_CHECK_W = 8;

    typedef logic [ECC_DATA_W-1:0]  ecc_data_t;
    typedef logic [ECC_CHECK_W-1:0] ecc_check_t;

    // Syndrome of a single error in each data bit.
    // Low seven bits are the Hamming position, bit 7 makes the weight odd.
    localparam ecc_check_t ECC_COL_CODES [ECC_DATA_W] = '{
        8'b1000_0011, // Bit 0.
        8'b1000_0101,
        8'b1000_0110,
        8'b0000_0111,
        8'b1000_1001,
        8'b1000_1010,
        8'b0000_1011,
        8'b1000_1100,
        8'b0000_1101,
        8'b0000_1110,
        8'b1000_1111,

        8'b1001_0001, // Bit 11.
        8'b1001_0010,
        8'b0001_0011,
        8'b1001_0100,
        8'b0001_0101,
        8'b0001_0110,
        8'b1001_0111,
        8'b1001_1000,
        8'b0001_1001,
        8'b0001_1010,
        8'b1001_1011,
        8'b0001_1100,
        8'b1001_1101,
        8'b1001_1110,
        8'b0001_1111,

        8'b1010_0001, // Bit 26.
        8'b1010_0010,
        8'b0010_0011,
        8'b1010_0100,
        8'b0010_0101,
        8'b0010_0110,
        8'b1010_0111,
        8'b1010_1000,
        8'b0010_1001,
        8'b0010_1010,
        8'b1010_1011,
        8'b0010_1100,
        8'b1010_1101,
        8'b1010_1110,
        8'b0010_1111,
        8'b1011_0000,
        8'b0011_0001,
        8'b0011_0010,
        8'b1011_0011,
        8'b0011_0100,
        8'b1011_0101,
        8'b1011_0110,
        8'b0011_0111,
        8'b0011_1000,
        8'b1011_1001,
        8'b1011_1010,
        8'b0011_1011,
        8'b1011_1100,
        8'b0011_1101,
        8'b0011_1110,
        8'b1011_1111,

        8'b1100_0001, // Bit 57.
        8'b1100_0010,
        8'b0100_0011,
        8'b1100_0100,
        8'b0100_0101,
        8'b0100_0110,
        8'b1100_0111,
        8'b1100_1000,
        8'b0100_1001,
        8'b0100_1010,
        8'b1100_1011,
        8'b0100_1100,
        8'b1100_1101,
        8'b1100_1110,
        8'b0100_1111,
        8'b1101_0000,
        8'b0101_0001,
        8'b0101_0010,
        8'b1101_0011,
        8'b0101_0100,
        8'b1101_0101,
        8'b1101_0110,
        8'b0101_0111,
        8'b0101_1000,
        8'b1101_1001,
        8'b1101_1010,
        8'b0101_1011,
        8'b1101_1100,
        8'b0101_1101,
        8'b0101_1110,
        8'b1101_1111,

        8'b1110_0000, // Bit 88, both upper groups.
        8'b0110_0001,
        8'b0110_0010,
        8'b1110_0011
    };

endpackage

//--- src/ecc_check_encoder.sv
module ecc_check_encoder
    import ecc_pkg::*;
(
    input  ecc_data_t  data,
    output ecc_check_t check
);

    // Data bits that feed one check bit.
    function automatic ecc_data_t cover_mask(input int check_idx);
        ecc_data_t m;
        m = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            m[i] = ECC_COL_CODES[i][check_idx];
        end
        return m;
    endfunction

    for (genvar j = 0; j < ECC_CHECK_W; j++) begin : g_check
        assign check[j] = ^(data & cover_mask(j));
    end

endmodule

//--- src/ecc_syndrome_stage.sv
module ecc_syndrome_stage
    import ecc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ecc_data_t  data_in,
    input  ecc_check_t parity_in,
    input  logic       bypass,
    output ecc_check_t parity_out,
    output ecc_data_t  stage_data,
    output ecc_check_t stage_syndrome,
    output logic       stage_bypass
);

    ecc_check_t syndrome;

    ecc_check_encoder encoder_i (
        .data  (data_in),
        .check (parity_out)
    );

    // Zero for a consistent codeword.
    assign syndrome = parity_in ^ parity_out;

    // Timing cut between the XOR trees and the syndrome match.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_data     <= '0;
            stage_syndrome <= '0;
            stage_bypass   <= 1'b0;
        end else begin
            stage_data     <= data_in;
            stage_syndrome <= syndrome;
            stage_bypass   <= bypass;
        end
    end

endmodule

//--- src/ecc_corrector.sv
module ecc_corrector
    import ecc_pkg::*;
(
    input  ecc_data_t  stage_data,
    input  ecc_check_t stage_syndrome,
    input  logic       stage_bypass,
    output ecc_data_t  data_out,
    output logic       sbit_err,
    output logic       dbit_err
);

    ecc_data_t  flip_mask;
    ecc_check_t syn_less_one;
    logic       syn_zero;
    logic       col_hit;
    logic       check_hit;
    logic       single;

    // At most one column matches, the codes are distinct.
    always_comb begin
        for (int i = 0; i < ECC_DATA_W; i++) begin
            flip_mask[i] = (stage_syndrome == ECC_COL_CODES[i]);
        end
    end

    assign syn_less_one = stage_syndrome - ECC_CHECK_W'(1);
    assign syn_zero     = (stage_syndrome == '0);
    assign col_hit      = |flip_mask;

    // One-hot syndrome means the stored check bit itself flipped.
    assign check_hit = !syn_zero && ((stage_syndrome & syn_less_one) == '0);
    assign single    = col_hit || check_hit;

    assign data_out = stage_bypass ? stage_data : (stage_data ^ flip_mask);
    assign sbit_err = !stage_bypass && single;
    assign dbit_err = !stage_bypass && !syn_zero && !single; // Even weight.

endmodule

//--- src/ecc_92_cal.sv
module ecc_92_cal
    import ecc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ecc_data_t  data_in,
    output ecc_data_t  data_out,
    input  ecc_check_t parity_in,
    output ecc_check_t parity_out,
    input  logic       bypass,
    output logic       sbit_err,
    output logic       dbit_err
);

    ecc_data_t  stage_data;
    ecc_check_t stage_syndrome;
    logic       stage_bypass;

    ecc_syndrome_stage syndrome_stage_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .parity_in      (parity_in),
        .bypass         (bypass),
        .parity_out     (parity_out),
        .stage_data     (stage_data),
        .stage_syndrome (stage_syndrome),
        .stage_bypass   (stage_bypass)
    );

    // Outputs lag the inputs by one clock.
    ecc_corrector corrector_i (
        .stage_data     (stage_data),
        .stage_syndrome (stage_syndrome),
        .stage_bypass   (stage_bypass),
        .data_out       (data_out),
        .sbit_err       (sbit_err),
        .dbit_err       (dbit_err)
    );

endmodule

//--- dv/ecc_92_cal_assertions.sv
module ecc_92_cal_assertions
    import ecc_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input ecc_data_t  data_in,
    input ecc_data_t  data_out,
    input ecc_check_t parity_in,
    input ecc_check_t parity_out,
    input logic       bypass,
    input logic       sbit_err,
    input logic       dbit_err
);

    timeunit 1ns;
    timeprecision 1ps;

    int         fail_count = 0;
    logic       primed = 1'b0; // Low until one edge has been seen.
    logic       prev_rst_n;
    ecc_data_t  prev_data;
    ecc_check_t prev_parity;
    logic       prev_bypass;
    ecc_check_t prev_syn;

    // Reference check bits straight from the column table.
    function automatic ecc_check_t table_check(input ecc_data_t d);
        ecc_check_t c;
        c = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (d[i]) begin
                c = c ^ ECC_COL_CODES[i];
            end
        end
        return c;
    endfunction

    function automatic logic is_single(input ecc_check_t syn);
        logic hit;
        hit = $onehot(syn); // Stored check bit flipped.
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (syn == ECC_COL_CODES[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always @(posedge clk) begin
        primed      <= 1'b1;
        prev_rst_n  <= rst_n;
        prev_data   <= data_in;
        prev_parity <= parity_in;
        prev_bypass <= bypass;
    end

    assign prev_syn = prev_parity ^ table_check(prev_data);

    a_reset: assert property (@(posedge clk)
        primed && !prev_rst_n |-> data_out == '0 && !sbit_err && !dbit_err)
    else begin
        fail_count++;
        $error("Error reset: expected data_out 0 sbit_err 0 dbit_err 0, actual %h %b %b",
            $sampled(data_out), $sampled(sbit_err), $sampled(dbit_err));
    end

    a_encode: assert property (@(posedge clk) parity_out == table_check(data_in))
    else begin
        fail_count++;
        $error("Error encode: expected parity_out %h, actual %h",
            table_check($sampled(data_in)), $sampled(parity_out));
    end

    a_clean: assert property (@(posedge clk)
        primed && prev_rst_n && !prev_bypass && prev_syn == '0
        |-> data_out == prev_data && !sbit_err && !dbit_err)
    else begin
        fail_count++;
        $error("Error clean: expected data_out %h flags 00, actual %h flags %b%b",
            $sampled(prev_data), $sampled(data_out), $sampled(sbit_err), $sampled(dbit_err));
    end

    // Corrected data must encode back to the stored bits, give or take the flipped one.
    a_single: assert property (@(posedge clk)
        primed && prev_rst_n && !prev_bypass && is_single(prev_syn)
        |-> sbit_err && !dbit_err && $countones(table_check(data_out) ^ prev_parity) <= 1)
    else begin
        fail_count++;
        $error("Error single: expected flags 10 check near %h, actual flags %b%b check %h",
            $sampled(prev_parity), $sampled(sbit_err), $sampled(dbit_err),
            table_check($sampled(data_out)));
    end

    a_double: assert property (@(posedge clk)
        primed && prev_rst_n && !prev_bypass && prev_syn != '0 && !is_single(prev_syn)
        |-> dbit_err && !sbit_err && data_out == prev_data)
    else begin
        fail_count++;
        $error("Error double: expected data_out %h flags 01, actual %h flags %b%b",
            $sampled(prev_data), $sampled(data_out), $sampled(sbit_err), $sampled(dbit_err));
    end

    a_bypass: assert property (@(posedge clk)
        primed && prev_rst_n && prev_bypass
        |-> data_out == prev_data && !sbit_err && !dbit_err)
    else begin
        fail_count++;
        $error("Error bypass: expected data_out %h flags 00, actual %h flags %b%b",
            $sampled(prev_data), $sampled(data_out), $sampled(sbit_err), $sampled(dbit_err));
    end

endmodule

bind ecc_92_cal ecc_92_cal_assertions assertions_i (.*);

//--- dv/ecc_92_cal_tb.sv
module ecc_92_cal_tb
    import ecc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk;
    logic       rst_n;
    ecc_data_t  data_in;
    ecc_data_t  data_out;
    ecc_check_t parity_in;
    ecc_check_t parity_out;
    logic       bypass;
    logic       sbit_err;
    logic       dbit_err;
    int         seed;

    ecc_92_cal ecc_92_cal_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .data_out   (data_out),
        .parity_in  (parity_in),
        .parity_out (parity_out),
        .bypass     (bypass),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    task automatic report_failure(input string why);
        $display("Failure: %s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped.");
    endtask

    // Check bit j is the parity of the data bits whose column has bit j set.
    task automatic calc_check(input ecc_data_t word, output ecc_check_t check);
        check = '0;
        for (int j = 0; j < ECC_CHECK_W; j++) begin
            for (int i = 0; i < ECC_DATA_W; i++) begin
                if (ECC_COL_CODES[i][j] && word[i]) begin
                    check[j] = ~check[j];
                end
            end
        end
    endtask

    task automatic random_word(output ecc_data_t word);
        word = ecc_data_t'({$random(seed), $random(seed), $random(seed)});
    endtask

    task automatic random_index(input int range, output int idx);
        idx = int'($unsigned($random(seed)) % range);
    endtask

    // Positions 92 and up address the check bits.
    task automatic flip_position(input int pos, inout ecc_data_t word,
                                 inout ecc_check_t check);
        if (pos < ECC_DATA_W) begin
            word[pos] = ~word[pos];
        end else begin
            check[pos - ECC_DATA_W] = ~check[pos - ECC_DATA_W];
        end
    endtask

    task automatic drive_word(input ecc_data_t word, input ecc_check_t check,
                              input logic byp);
        @(negedge clk);
        data_in   = word;
        parity_in = check;
        bypass    = byp;
    endtask

    task automatic wait_outputs_idle();
        int cycles;
        cycles = 0;
        while (data_out !== '0 || sbit_err !== 1'b0 || dbit_err !== 1'b0) begin
            if (cycles == 32) begin
                report_failure("outputs did not clear while reset was held");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Any assertion failure ends the run at the next falling edge.
    always @(negedge clk) begin
        if (ecc_92_cal_i.assertions_i.fail_count != 0) begin
            report_failure("an assertion failed, see the error above");
        end
    end

    initial begin
        ecc_data_t  word;
        ecc_check_t check;
        int         pos_a;
        int         pos_b;
        int         count;

        seed      = 32'he401_e872;
        rst_n     = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;

        // Random traffic while in reset must not reach the outputs.
        for (int n = 0; n < 16; n++) begin
            random_word(word);
            random_index(2, count);
            drive_word(word, ecc_check_t'($random(seed)), count[0]);
        end
        wait_outputs_idle();
        rst_n = 1'b1;

        for (int n = 0; n < 64; n++) begin
            random_word(word);
            calc_check(word, check);
            drive_word(word, check, 1'b0);
        end

        for (int n = 0; n < 192; n++) begin
            random_word(word);
            calc_check(word, check);
            random_index(ECC_DATA_W, pos_a);
            flip_position(pos_a, word, check);
            drive_word(word, check, 1'b0);
        end

        for (int n = 0; n < 32; n++) begin
            random_word(word);
            calc_check(word, check);
            random_index(ECC_CHECK_W, pos_a);
            flip_position(ECC_DATA_W + pos_a, word, check);
            drive_word(word, check, 1'b0);
        end

        // Second position is offset from the first so the two never coincide.
        for (int n = 0; n < 128; n++) begin
            random_word(word);
            calc_check(word, check);
            random_index(ECC_DATA_W + ECC_CHECK_W, pos_a);
            random_index(ECC_DATA_W + ECC_CHECK_W - 1, pos_b);
            pos_b = (pos_a + 1 + pos_b) % (ECC_DATA_W + ECC_CHECK_W);
            flip_position(pos_a, word, check);
            flip_position(pos_b, word, check);
            drive_word(word, check, 1'b0);
        end

        for (int n = 0; n < 48; n++) begin
            random_word(word);
            calc_check(word, check);
            random_index(ECC_DATA_W + ECC_CHECK_W, pos_a);
            flip_position(pos_a, word, check);
            random_index(2, count);
            if (count == 1) begin
                random_index(ECC_DATA_W + ECC_CHECK_W - 1, pos_b);
                pos_b = (pos_a + 1 + pos_b) % (ECC_DATA_W + ECC_CHECK_W);
                flip_position(pos_b, word, check);
            end
            drive_word(word, check, 1'b1);
        end

        // Let the last word come out and be checked.
        random_word(word);
        calc_check(word, check);
        drive_word(word, check, 1'b0);
        repeat (3) @(negedge clk);

        if (ecc_92_cal_i.assertions_i.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_failure("an assertion failed in the final cycles");
        end
    end

endmodule

//--- vlog.f
src/ecc_pkg.sv
src/ecc_check_encoder.sv
src/ecc_syndrome_stage.sv
src/ecc_corrector.sv
src/ecc_92_cal.sv
dv/ecc_92_cal_assertions.sv
dv/ecc_92_cal_tb.sv
